// ==== build.f ====
hw/dma_pkg.sv
hw/rd_ctrl.sv
hw/pkt_fifo.sv
hw/pkt_sink.sv
hw/dma_read_top.sv
verif/avalon_mem_model.sv
verif/dma_read_chk.sv
verif/tb_dma_read.sv

// ==== hw/dma_pkg.sv ====
package dma_pkg;

    // bus widths
    localparam int WORD_W  = 32;
    localparam int ADDR_W  = 32;
    localparam int BURST_W = 16;    // matches the avalon burstcount port

    // byte symbols per readdata word
    localparam int BYTES_PER_WORD = WORD_W / 8;

    // one data word as returned by memory
    typedef logic [WORD_W-1:0] word_t;

    // byte address on the avalon side
    typedef logic [ADDR_W-1:0] addr_t;

    // burst length in words
    typedef logic [BURST_W-1:0] burst_t;

endpackage

// ==== hw/dma_read_top.sv ====
`timescale 1ns/1ps

module dma_read_top import dma_pkg::*; #(
    parameter int MAX_BURST  = 4,
    parameter int FIFO_DEPTH = 16     // at least 2*MAX_BURST
) (
    input  logic   clk,
    input  logic   reset,
    // host side
    input  logic   start,
    input  addr_t  pkt_begin,
    input  addr_t  pkt_end,
    input  logic   out_stall,
    output logic   busy,
    output logic   done,
    output word_t  out_data,
    output logic   out_valid,
    output word_t  pkt_sum,
    output logic   sum_valid,
    // avalon-mm master
    output addr_t  address,
    output logic   read,
    output burst_t burstcount,
    input  word_t  readdata,
    input  logic   readdatavalid,
    input  logic   waitrequest
);

    logic   push, pop, empty, almost_full, pkt_start;
    word_t  push_data, pop_data;
    burst_t pkt_words;

    rd_ctrl #(
        .MAX_BURST (MAX_BURST)
    ) u_rd_ctrl (
        .clk, .reset, .start, .pkt_begin, .pkt_end, .almost_full,
        .address, .read, .burstcount, .readdata, .readdatavalid, .waitrequest,
        .push, .push_data, .pkt_start, .pkt_words, .busy, .done
    );

    pkt_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .MAX_BURST  (MAX_BURST),
        .payload_t  (word_t)
    ) u_fifo (
        .clk, .reset, .push, .push_data, .pop, .pop_data, .empty, .almost_full
    );

    pkt_sink u_sink (
        .clk, .reset, .pkt_start, .pkt_words, .empty, .out_stall, .pop, .pop_data,
        .out_data, .out_valid, .pkt_sum, .sum_valid
    );

endmodule

// ==== hw/pkt_fifo.sv ====
`timescale 1ns/1ps

module pkt_fifo #(
    parameter int  FIFO_DEPTH = 16,
    parameter int  MAX_BURST  = 4,
    parameter type payload_t  = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     almost_full
);

    localparam int PTR_W    = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W    = $clog2(FIFO_DEPTH + 1);
    // leave room for one whole burst still in flight
    localparam int AF_LEVEL = FIFO_DEPTH - MAX_BURST;

    payload_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count;

    assign pop_data    = mem[rd_ptr];   // show-ahead head
    assign empty       = (count == '0);
    assign almost_full = (count >= CNT_W'(AF_LEVEL));

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

endmodule

// ==== hw/pkt_sink.sv ====
`timescale 1ns/1ps

module pkt_sink import dma_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   pkt_start,
    input  burst_t pkt_words,
    input  logic   empty,
    input  logic   out_stall,
    output logic   pop,
    input  word_t  pop_data,
    output word_t  out_data,
    output logic   out_valid,
    output word_t  pkt_sum,
    output logic   sum_valid
);

    burst_t words_q;    // expected length of the current packet
    burst_t count;
    logic   armed;      // packet open, checksum not yet reported

    // drain whenever something is there and the output is free
    assign pop = !empty && !out_stall;

    always_ff @(posedge clk) begin
        if (!reset)
            out_valid <= 1'b0;
        else
            out_valid <= pop;
    end

    always_ff @(posedge clk) begin
        out_data <= pop_data;
    end

    always_ff @(posedge clk) begin
        if (pkt_start)
            words_q <= pkt_words;
    end

    // count and checksum over the output words
    always_ff @(posedge clk) begin
        if (!reset) begin
            count     <= '0;
            pkt_sum   <= '0;
            armed     <= 1'b0;
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= 1'b0;
            if (pkt_start) begin
                count   <= '0;
                pkt_sum <= '0;
                armed   <= 1'b1;
            end else if (out_valid) begin
                count   <= count + 1'b1;
                pkt_sum <= pkt_sum + out_data;     // wraps mod 2^32
                if (armed && (count + 1'b1) == words_q) begin
                    sum_valid <= 1'b1;
                    armed     <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== hw/rd_ctrl.sv ====
`timescale 1ns/1ps

module rd_ctrl import dma_pkg::*; #(
    parameter int MAX_BURST = 4
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   start,
    input  addr_t  pkt_begin,
    input  addr_t  pkt_end,
    input  logic   almost_full,
    // avalon-mm read master
    output addr_t  address,
    output logic   read,
    output burst_t burstcount,
    input  word_t  readdata,
    input  logic   readdatavalid,
    input  logic   waitrequest,
    // buffer write side
    output logic   push,
    output word_t  push_data,
    // packet info for the consumer
    output logic   pkt_start,
    output burst_t pkt_words,
    output logic   busy,
    output logic   done
);

    typedef enum logic [1:0] {IDLE, RUN, DONE} state_t;

    state_t state;

    addr_t  begin_q, end_q;     // latched byte range
    logic   start_q;            // registered start, loads the counters
    logic [ADDR_W-1:0] words_left;  // words not yet requested
    burst_t beats_left;         // beats still due in the current burst
    burst_t next_burst;
    logic   issue;

    // burst size is the smaller of MAX_BURST and what is left
    assign next_burst = (words_left < MAX_BURST) ? burst_t'(words_left) : burst_t'(MAX_BURST);

    // new burst once the previous one has fully returned and there is room
    assign issue = (state == RUN) && !start_q && !read && (beats_left == '0) &&
                   (words_left != '0) && !almost_full;

    assign busy = (state != IDLE);
    assign done = (state == DONE);   // one cycle, then back to idle

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (start) state <= RUN;
                RUN: begin
                    // last beat has just been pushed
                    if (push && !start_q && !read && beats_left == '0 && words_left == '0)
                        state <= DONE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // start capture
    always_ff @(posedge clk) begin
        if (!reset) begin
            start_q   <= 1'b0;
            pkt_start <= 1'b0;
        end else begin
            start_q   <= start && (state == IDLE);
            pkt_start <= start && (state == IDLE);
        end
    end

    always_ff @(posedge clk) begin
        if (start && state == IDLE) begin
            begin_q   <= pkt_begin;
            end_q     <= pkt_end;
            pkt_words <= burst_t'((pkt_end - pkt_begin) / BYTES_PER_WORD);
        end
    end

    // word and beat counters
    always_ff @(posedge clk) begin
        if (!reset) begin
            words_left <= '0;
            beats_left <= '0;
        end else begin
            if (start_q)
                words_left <= (end_q - begin_q) / BYTES_PER_WORD;
            else if (issue)
                words_left <= words_left - next_burst;

            if (issue)
                beats_left <= next_burst;
            else if (readdatavalid && beats_left != '0)
                beats_left <= beats_left - 1'b1;
        end
    end

    // avalon command, held until waitrequest drops
    always_ff @(posedge clk) begin
        if (!reset) begin
            read <= 1'b0;
        end else if (issue) begin
            read <= 1'b1;
        end else if (!waitrequest) begin
            read <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_q)
            address <= begin_q;
        else if (read && !waitrequest)
            address <= address + addr_t'(burstcount) * BYTES_PER_WORD;  // next burst base

        if (issue)
            burstcount <= next_burst;
    end

    // every returned beat goes to the buffer one cycle later
    always_ff @(posedge clk) begin
        if (!reset)
            push <= 1'b0;
        else
            push <= readdatavalid && (state == RUN);
    end

    always_ff @(posedge clk) begin
        push_data <= readdata;
    end

endmodule

// ==== verif/avalon_mem_model.sv ====
`timescale 1ns/1ps

module avalon_mem_model import dma_pkg::*; #(
    parameter int WAIT_PCT = 30,    // chance of waitrequest in a cycle
    parameter int GAP_PCT  = 40     // chance of holding back a due beat
) (
    input  logic   clk,
    input  logic   reset,
    input  addr_t  address,
    input  logic   read,
    input  burst_t burstcount,
    output word_t  readdata,
    output logic   readdatavalid,
    output logic   waitrequest
);

    addr_t beat_q [$];      // byte addresses of beats still owed
    addr_t beat_addr;

    initial begin
        readdata      <= '0;
        readdatavalid <= 1'b0;
        waitrequest   <= 1'b1;
    end

    always @(posedge clk) begin
        if (!reset) begin
            readdatavalid <= 1'b0;
            waitrequest   <= 1'b1;
            beat_q.delete();
        end else begin
            // return side, random gaps give a random latency
            if (beat_q.size() != 0 && $urandom_range(99) >= GAP_PCT) begin
                beat_addr = beat_q.pop_front();
                readdata      <= beat_addr ^ 32'hA5A5_0000;
                readdatavalid <= 1'b1;
            end else begin
                readdatavalid <= 1'b0;
            end

            // command accepted this cycle
            if (read && !waitrequest) begin
                for (int i = 0; i < int'(burstcount); i++)
                    beat_q.push_back(address + addr_t'(i * BYTES_PER_WORD));
            end

            waitrequest <= ($urandom_range(99) < WAIT_PCT);
        end
    end

endmodule

// ==== verif/dma_read_chk.sv ====
`timescale 1ns/1ps

module dma_read_chk import dma_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input logic   clk,
    input logic   reset,
    input logic   read,
    input logic   waitrequest,
    input addr_t  address,
    input burst_t burstcount,
    input logic   push,
    input logic   pop,
    input logic   done,
    input logic   busy
);

    int fail_count = 0;     // failed assertions so far

    logic [$clog2(FIFO_DEPTH+1)-1:0] occ;   // buffer occupancy, tracked from push and pop

    always_ff @(posedge clk) begin
        if (!reset)
            occ <= '0;
        else if (push && !pop)
            occ <= occ + 1'b1;
        else if (pop && !push)
            occ <= occ - 1'b1;
    end

    a_cmd_hold: assert property (@(posedge clk) disable iff (!reset)
        read && waitrequest |=> read && $stable(address) && $stable(burstcount))
    else begin
        $error("avalon read command changed while waitrequest was high");
        fail_count++;
    end

    a_push_full: assert property (@(posedge clk) disable iff (!reset)
        !(push && occ == FIFO_DEPTH))
    else begin
        $error("push into a full buffer");
        fail_count++;
    end

    // done comes only while busy, right after the last push
    a_done_busy: assert property (@(posedge clk) disable iff (!reset)
        done |-> busy && $past(push))
    else begin
        $error("done high while busy is low or without a push just before it");
        fail_count++;
    end

endmodule

bind dma_read_top dma_read_chk #(.FIFO_DEPTH(FIFO_DEPTH)) u_chk (
    .clk(clk), .reset(reset), .read(read), .waitrequest(waitrequest),
    .address(address), .burstcount(burstcount), .push(push), .pop(pop),
    .done(done), .busy(busy)
);

// ==== verif/dma_stim.txt ====
// columns in hex: begin end stall_pct words checksum
// stall_pct is the out_stall chance per cycle, words and checksum are the expected results
00000000 00000040 00 10 5A5001E0
00000100 0000011C 14 07 87830754
00000200 00000204 32 01 A5A50200
00000400 000004A0 5A 28 E1C8AC30
00001000 00001014 00 05 3C395028
00010000 00010018 1E 06 E1D8003C
00002000 00002080 4B 20 B4A407C0
00003000 0000300C 0A 03 F0EF900C

// ==== verif/tb_dma_read.sv ====
`timescale 1ns/1ps

module tb_dma_read import dma_pkg::*; ();

    localparam int MAX_BURST  = 4;
    localparam int FIFO_DEPTH = 16;
    localparam int STIM_COLS  = 5;      // begin, end, stall %, words, checksum
    localparam int STIM_LINES = 32;

    logic   clk, reset, start, out_stall;
    addr_t  pkt_begin, pkt_end;
    logic   busy, done, out_valid, sum_valid;
    word_t  out_data, pkt_sum;
    addr_t  address;
    logic   read, readdatavalid, waitrequest;
    burst_t burstcount;
    word_t  readdata;

    logic [31:0] stim [STIM_LINES*STIM_COLS];
    word_t exp_q [$];       // words still due on out_data
    word_t exp_sum;
    int    n_lines;
    int    wd_cycles = 0;
    int    done_seen, sum_seen;
    logic  done_prev;

    dma_read_top #(.MAX_BURST(MAX_BURST), .FIFO_DEPTH(FIFO_DEPTH)) dut (
        .clk, .reset, .start, .pkt_begin, .pkt_end, .out_stall, .busy, .done,
        .out_data, .out_valid, .pkt_sum, .sum_valid,
        .address, .read, .burstcount, .readdata, .readdatavalid, .waitrequest
    );

    avalon_mem_model u_mem (
        .clk, .reset, .address, .read, .burstcount, .readdata, .readdatavalid, .waitrequest
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // memory contents, word at byte address a
    function automatic word_t mem_word(addr_t a);
        return a ^ 32'hA5A5_0000;
    endfunction

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(string name, word_t expected, word_t actual);
        assert (actual === expected) else begin
            $display("ERROR at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    // output monitor, sees the values from before the edge
    always @(posedge clk) begin
        if (reset) begin
            assert (dut.u_chk.fail_count == 0) else begin
                $display("ERROR at %0t ns: a protocol assertion on the avalon or buffer side failed",
                         $time);
                abort_run();
            end
            if (out_valid) begin
                assert (exp_q.size() != 0) else begin
                    $display("ERROR at %0t ns: extra word %h on out_data", $time, out_data);
                    abort_run();
                end
                check_value("out_data", exp_q.pop_front(), out_data);
            end
            if (sum_valid) begin
                sum_seen++;
                check_value("sum_valid pulses", 1, sum_seen);
                check_value("words missing at sum_valid", 0, exp_q.size());
                check_value("pkt_sum", exp_sum, pkt_sum);
            end
            if (done) begin
                done_seen++;
                check_value("done pulses", 1, done_seen);
            end
            check_value("busy after done", 0, done_prev && busy);
            done_prev = done;
            if (read && !waitrequest) begin
                assert (burstcount >= 1 && burstcount <= MAX_BURST) else begin
                    $display("ERROR at %0t ns: burstcount %0d is outside 1 to %0d",
                             $time, burstcount, MAX_BURST);
                    abort_run();
                end
            end
        end
    end

    initial begin
        addr_t a_begin, a_end;
        int    pct, n_words, age;
        word_t file_sum, calc_sum;
        bit    extra_sent;

        void'($urandom(65027));
        reset = 1'b0;
        start = 1'b0;
        pkt_begin = '0;
        pkt_end = '0;
        out_stall = 1'b0;
        done_prev = 1'b0;
        done_seen = 0;
        sum_seen = 0;

        foreach (stim[i]) stim[i] = '0;
        $readmemh("verif/dma_stim.txt", stim);
        n_lines = 0;    // a zero-length line ends the list
        while (n_lines < STIM_LINES && stim[n_lines*STIM_COLS+1] != stim[n_lines*STIM_COLS])
            n_lines++;
        assert (n_lines > 0) else begin
            $display("ERROR: the stimulus file holds no transfers");
            abort_run();
        end
        for (int l = 0; l < n_lines; l++)
            wd_cycles += (stim[l*STIM_COLS+3] + 20) * 10;

        repeat (2) @(negedge clk);
        reset = 1'b1;
        check_value("read", 0, read);
        check_value("out_valid", 0, out_valid);
        check_value("sum_valid", 0, sum_valid);
        check_value("done", 0, done);
        check_value("busy", 0, busy);

        for (int l = 0; l < n_lines; l++) begin
            a_begin  = stim[l*STIM_COLS];
            a_end    = stim[l*STIM_COLS+1];
            pct      = stim[l*STIM_COLS+2];
            n_words  = stim[l*STIM_COLS+3];
            file_sum = stim[l*STIM_COLS+4];
            calc_sum = '0;
            for (addr_t a = a_begin; a != a_end; a += BYTES_PER_WORD) begin
                exp_q.push_back(mem_word(a));
                calc_sum += mem_word(a);
            end
            check_value("stim word count", n_words, (a_end - a_begin) / BYTES_PER_WORD);
            check_value("stim checksum", calc_sum, file_sum);
            exp_sum   = calc_sum;
            done_seen = 0;
            sum_seen  = 0;

            @(negedge clk);
            pkt_begin = a_begin;
            pkt_end   = a_end;
            start     = 1'b1;
            @(negedge clk);
            start = 1'b0;
            check_value("busy", 1, busy);

            extra_sent = 1'b0;
            age = 0;
            while (done_seen == 0 || sum_seen == 0) begin
                out_stall = ($urandom_range(99) < pct);
                if (!extra_sent && age == 3 && busy) begin
                    start     = 1'b1;   // must be ignored while busy
                    pkt_begin = 32'hDEAD_0000;
                    pkt_end   = 32'hDEAD_0100;
                    extra_sent = 1'b1;
                end else begin
                    start = 1'b0;
                end
                @(negedge clk);
                age++;
            end
            start = 1'b0;
            out_stall = 1'b0;

            repeat (8) @(negedge clk);  // quiet window, nothing more may show up
            check_value("done pulses", 1, done_seen);
            check_value("sum_valid pulses", 1, sum_seen);
            check_value("words missing", 0, exp_q.size());
        end

        if (dut.u_chk.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("ERROR: %0d protocol assertion failures", dut.u_chk.fail_count);
            $display("test failed");
        end
        $finish;
    end

    initial begin
        @(posedge reset);
        repeat (wd_cycles) @(posedge clk);
        $display("ERROR: timeout, the transfers did not finish within %0d cycles", wd_cycles);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

endmodule
